//--- include/rv_pipe_settings.svh
`ifndef RV_PIPE_SETTINGS_SVH
`define RV_PIPE_SETTINGS_SVH

// Fetch address after reset
`define RESET_PC 32'h0001_0000

// Data path and bus width
`define XLEN 32

// Register file address width
`define REG_ADDR_W 5

`endif

//--- source/rv_pipe_pkg.sv
`include "rv_pipe_settings.svh"

package rv_pipe_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]             imm_11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_4_0;
        logic [6:0]             opcode;
    } s_type_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        logic [6:0]             opcode;
    } b_type_t;

    // One instruction word, four ways to read it
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
    } instr_u;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        instr_u           ir;
        logic             valid;
    } if_id_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        opcode_e                opcode;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       data1;
        logic [`XLEN-1:0]       data2;
        logic                   valid;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       b;
        logic [`XLEN-1:0]       c;
        logic                   jump;
        logic [`XLEN-1:0]       target;
        logic                   valid;
    } ex_mem_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       c;
        logic [`XLEN-1:0]       d;
        logic                   valid;
    } mem_wb_t;

endpackage

//--- source/id_stage.sv
`timescale 1ns/1ps
`include "rv_pipe_settings.svh"

module id_stage (
    input  rv_pipe_pkg::instr_u    ir,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd,
    output rv_pipe_pkg::opcode_e   opcode,
    output logic [2:0]             funct3,
    output logic [6:0]             funct7,
    output logic [`XLEN-1:0]       imm
);

    // Register and function fields sit at the same bits in every format
    assign rs1    = ir.r.rs1;
    assign rs2    = ir.r.rs2;
    assign rd     = ir.r.rd;
    assign funct3 = ir.r.funct3;
    assign funct7 = ir.r.funct7;
    assign opcode = rv_pipe_pkg::opcode_e'(ir.r.opcode);

    // Immediate assembly with the sign always from instruction bit 31
    always_comb begin
        case (opcode)
            rv_pipe_pkg::OP_IMM,
            rv_pipe_pkg::LOAD,
            rv_pipe_pkg::JALR: begin
                imm = {{20{ir.i.imm[11]}}, ir.i.imm};
            end
            rv_pipe_pkg::STORE: begin
                imm = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
            end
            rv_pipe_pkg::BRANCH: begin
                imm = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11,
                       ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
            end
            rv_pipe_pkg::LUI,
            rv_pipe_pkg::AUIPC: begin
                // Upper twenty bits, low twelve cleared
                imm = {ir.i.imm, ir.i.rs1, ir.i.funct3, 12'h000};
            end
            rv_pipe_pkg::JAL: begin
                // J-type bits 19:12 occupy the rs1 and funct3 slots
                imm = {{11{ir.i.imm[11]}}, ir.i.imm[11], ir.i.rs1, ir.i.funct3,
                       ir.i.imm[0], ir.i.imm[10:1], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- source/rf32x32.sv
`timescale 1ns/1ps
`include "rv_pipe_settings.svh"

module rf32x32 (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]       data_in,
    input  logic [`REG_ADDR_W-1:0] rd1_addr,
    input  logic [`REG_ADDR_W-1:0] rd2_addr,
    output logic [`XLEN-1:0]       data1_out,
    output logic [`XLEN-1:0]       data2_out
);

    logic [`XLEN-1:0] regs [0:(1 << `REG_ADDR_W)-1];

    // x0 is hardwired, write data bypasses the array on a match
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en && (wr_addr == addr)) begin
            return data_in;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= data_in;
        end
    end

    assign data1_out = read_port(rd1_addr);
    assign data2_out = read_port(rd2_addr);

endmodule

//--- source/ex_stage.sv
`timescale 1ns/1ps
`include "rv_pipe_settings.svh"

module ex_stage (
    input  rv_pipe_pkg::id_ex_t id_ex,
    output logic                jump,
    output logic [`XLEN-1:0]    target,
    output logic [`XLEN-1:0]    b,
    output logic [`XLEN-1:0]    c
);

    logic [`XLEN-1:0]        op_b;
    logic [`XLEN-1:0]        alu_out;
    logic [`XLEN-1:0]        addr_sum;
    logic [`XLEN-1:0]        pc_rel;
    logic signed [`XLEN-1:0] sra_out;
    logic [4:0]              shamt;
    logic                    is_sub;
    logic                    eq;
    logic                    lt_s;
    logic                    lt_u;
    logic                    taken;

    // rs2 feeds the second operand for register ops and branch compares
    assign op_b = (id_ex.opcode == rv_pipe_pkg::OP || id_ex.opcode == rv_pipe_pkg::BRANCH)
                  ? id_ex.data2 : id_ex.imm;

    assign shamt    = op_b[4:0];
    assign is_sub   = (id_ex.opcode == rv_pipe_pkg::OP) && id_ex.funct7[5];
    assign sra_out  = $signed(id_ex.data1) >>> shamt;
    assign eq       = (id_ex.data1 == op_b);
    assign lt_s     = ($signed(id_ex.data1) < $signed(op_b));
    assign lt_u     = (id_ex.data1 < op_b);
    assign addr_sum = id_ex.data1 + id_ex.imm;
    assign pc_rel   = id_ex.pc + id_ex.imm;

    always_comb begin
        case (id_ex.funct3)
            3'b000:  alu_out = is_sub ? id_ex.data1 - op_b : id_ex.data1 + op_b;
            3'b001:  alu_out = id_ex.data1 << shamt;
            3'b010:  alu_out = {{(`XLEN-1){1'b0}}, lt_s};
            3'b011:  alu_out = {{(`XLEN-1){1'b0}}, lt_u};
            3'b100:  alu_out = id_ex.data1 ^ op_b;
            3'b101:  alu_out = id_ex.funct7[5] ? sra_out : id_ex.data1 >> shamt;
            3'b110:  alu_out = id_ex.data1 | op_b;
            default: alu_out = id_ex.data1 & op_b;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (id_ex.funct3)
            3'b000:  taken = eq;
            3'b001:  taken = !eq;
            3'b100:  taken = lt_s;
            3'b101:  taken = !lt_s;
            3'b110:  taken = lt_u;
            3'b111:  taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    assign jump = id_ex.valid && ((id_ex.opcode == rv_pipe_pkg::JAL)
                                  || (id_ex.opcode == rv_pipe_pkg::JALR)
                                  || ((id_ex.opcode == rv_pipe_pkg::BRANCH) && taken));

    // JALR drops bit 0 of the computed address
    assign target = (id_ex.opcode == rv_pipe_pkg::JALR) ? {addr_sum[`XLEN-1:1], 1'b0} : pc_rel;

    always_comb begin
        case (id_ex.opcode)
            rv_pipe_pkg::LOAD,
            rv_pipe_pkg::STORE: c = addr_sum;
            rv_pipe_pkg::LUI:   c = id_ex.imm;
            rv_pipe_pkg::AUIPC: c = pc_rel;
            default:            c = alu_out;
        endcase
    end

    assign b = id_ex.data2;

endmodule

//--- source/mem_stage.sv
`timescale 1ns/1ps
`include "rv_pipe_settings.svh"

module mem_stage (
    input  rv_pipe_pkg::ex_mem_t ex_mem,
    input  logic [`XLEN-1:0]     ddt_in,
    output logic                 mreq,
    output logic                 write,
    output logic [`XLEN-1:0]     ddt_out,
    output logic [`XLEN-1:0]     d
);

    logic is_load;
    logic is_store;

    assign is_load  = (ex_mem.opcode == rv_pipe_pkg::LOAD);
    assign is_store = (ex_mem.opcode == rv_pipe_pkg::STORE);

    // Bus request only for a live load or store
    assign mreq  = ex_mem.valid && (is_load || is_store);
    assign write = ex_mem.valid && is_store;

    // Write bus rests at zero outside stores
    assign ddt_out = write ? ex_mem.b : '0;

    // Captured into MEM/WB on the edge that completes the access
    assign d = ddt_in;

endmodule

//--- source/top.sv
`timescale 1ns/1ps
`include "rv_pipe_settings.svh"

module top (
    input  logic             clk,
    input  logic             rst_n,

    // Instruction memory
    output logic [`XLEN-1:0] iad,
    input  logic [`XLEN-1:0] idt,
    input  logic             acki_n,

    // Data memory
    output logic [`XLEN-1:0] dad,
    input  logic [`XLEN-1:0] ddt_in,
    output logic [`XLEN-1:0] ddt_out,
    output logic             mreq,
    output logic             write,
    output logic [1:0]       size,
    input  logic             ackd_n
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] next_pc;
    logic             stall;

    rv_pipe_pkg::if_id_t  if_id;
    rv_pipe_pkg::if_id_t  if_id_d;
    rv_pipe_pkg::id_ex_t  id_ex;
    rv_pipe_pkg::id_ex_t  id_ex_d;
    rv_pipe_pkg::ex_mem_t ex_mem;
    rv_pipe_pkg::ex_mem_t ex_mem_d;
    rv_pipe_pkg::mem_wb_t mem_wb;
    rv_pipe_pkg::mem_wb_t mem_wb_d;

    logic [`REG_ADDR_W-1:0] rs1_id;
    logic [`REG_ADDR_W-1:0] rs2_id;
    logic [`REG_ADDR_W-1:0] rd_id;
    rv_pipe_pkg::opcode_e   opcode_id;
    logic [2:0]             funct3_id;
    logic [6:0]             funct7_id;
    logic [`XLEN-1:0]       imm_id;
    logic [`XLEN-1:0]       data1_id;
    logic [`XLEN-1:0]       data2_id;

    logic                   jump_ex;
    logic [`XLEN-1:0]       target_ex;
    logic [`XLEN-1:0]       b_ex;
    logic [`XLEN-1:0]       c_ex;
    logic [`XLEN-1:0]       d_mem;

    logic                   wb_writes_rd;
    logic                   wb_en;
    logic [`XLEN-1:0]       wb_data;

    // Either memory holding off freezes the whole pipe
    assign stall = acki_n || (mreq && ackd_n);

    // Fetch. A taken jump in execute steers the next fetch,
    // so the two instructions behind it still complete
    assign iad     = pc;
    assign next_pc = jump_ex ? target_ex : pc + 4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    always_comb begin
        if_id_d.pc    = pc;
        if_id_d.ir    = idt;
        if_id_d.valid = 1'b1;

        id_ex_d.pc     = if_id.pc;
        id_ex_d.opcode = opcode_id;
        id_ex_d.funct3 = funct3_id;
        id_ex_d.funct7 = funct7_id;
        id_ex_d.rd     = rd_id;
        id_ex_d.imm    = imm_id;
        id_ex_d.data1  = data1_id;
        id_ex_d.data2  = data2_id;
        id_ex_d.valid  = if_id.valid;

        ex_mem_d.pc     = id_ex.pc;
        ex_mem_d.opcode = id_ex.opcode;
        ex_mem_d.rd     = id_ex.rd;
        ex_mem_d.b      = b_ex;
        ex_mem_d.c      = c_ex;
        ex_mem_d.jump   = jump_ex;
        ex_mem_d.target = target_ex;
        ex_mem_d.valid  = id_ex.valid;

        mem_wb_d.pc     = ex_mem.pc;
        mem_wb_d.opcode = ex_mem.opcode;
        mem_wb_d.rd     = ex_mem.rd;
        mem_wb_d.c      = ex_mem.c;
        mem_wb_d.d      = d_mem;
        mem_wb_d.valid  = ex_mem.valid;
    end

    // Stage boundary registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id.valid  <= 1'b0;
            id_ex.valid  <= 1'b0;
            ex_mem.valid <= 1'b0;
            mem_wb.valid <= 1'b0;
        end else if (!stall) begin
            if_id  <= if_id_d;
            id_ex  <= id_ex_d;
            ex_mem <= ex_mem_d;
            mem_wb <= mem_wb_d;
        end
    end

    id_stage id_stage_inst (
        .ir     (if_id.ir),
        .rs1    (rs1_id),
        .rs2    (rs2_id),
        .rd     (rd_id),
        .opcode (opcode_id),
        .funct3 (funct3_id),
        .funct7 (funct7_id),
        .imm    (imm_id)
    );

    rf32x32 regfile_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wb_en),
        .wr_addr   (mem_wb.rd),
        .data_in   (wb_data),
        .rd1_addr  (rs1_id),
        .rd2_addr  (rs2_id),
        .data1_out (data1_id),
        .data2_out (data2_id)
    );

    ex_stage ex_stage_inst (
        .id_ex  (id_ex),
        .jump   (jump_ex),
        .target (target_ex),
        .b      (b_ex),
        .c      (c_ex)
    );

    mem_stage mem_stage_inst (
        .ex_mem  (ex_mem),
        .ddt_in  (ddt_in),
        .mreq    (mreq),
        .write   (write),
        .ddt_out (ddt_out),
        .d       (d_mem)
    );

    assign dad  = ex_mem.c;
    // Word accesses only
    assign size = 2'b10;

    // Write-back source and whether rd is written at all
    always_comb begin
        case (mem_wb.opcode)
            rv_pipe_pkg::JAL,
            rv_pipe_pkg::JALR: begin
                wb_data      = mem_wb.pc + 4;
                wb_writes_rd = 1'b1;
            end
            rv_pipe_pkg::LOAD: begin
                wb_data      = mem_wb.d;
                wb_writes_rd = 1'b1;
            end
            rv_pipe_pkg::OP,
            rv_pipe_pkg::OP_IMM,
            rv_pipe_pkg::LUI,
            rv_pipe_pkg::AUIPC: begin
                wb_data      = mem_wb.c;
                wb_writes_rd = 1'b1;
            end
            default: begin
                wb_data      = mem_wb.c;
                wb_writes_rd = 1'b0;
            end
        endcase
    end

    // Write once, on the edge where the pipe moves
    assign wb_en = mem_wb.valid && wb_writes_rd && (mem_wb.rd != '0) && !stall;

endmodule

//--- tb/tb_top.sv
`timescale 1ns/1ps
`include "rv_pipe_settings.svh"

module tb_top;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 1024;
    localparam int CYCLES_PER_TEST = 200;

    // Test kinds
    localparam logic [3:0] K_RR    = 4'd0;
    localparam logic [3:0] K_IMM   = 4'd1;
    localparam logic [3:0] K_LUI   = 4'd2;
    localparam logic [3:0] K_AUIPC = 4'd3;
    localparam logic [3:0] K_LOAD  = 4'd4;
    localparam logic [3:0] K_BR    = 4'd5;
    localparam logic [3:0] K_JAL   = 4'd6;
    localparam logic [3:0] K_JALR  = 4'd7;

    localparam logic [31:0] NOP = 32'h0000_0013;

    typedef struct packed {
        logic [3:0]  kind;
        logic [3:0]  sel;
        logic [31:0] a;
        logic [31:0] b;
        logic        stall;
    } test_row_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] iad;
    logic [31:0] idt;
    logic        acki_n;
    logic [31:0] dad;
    logic [31:0] ddt_in;
    logic [31:0] ddt_out;
    logic        mreq;
    logic        write;
    logic [1:0]  size;
    logic        ackd_n;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] rng;
    logic        stall_mode;
    logic        pending;
    int          wait_left;
    int          cycles;
    int          limit;
    int          pc_idx;
    int          bus_errs;

    test_row_t   rows[$];
    string       labels[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    logic [31:0] got_addr[$];
    logic [31:0] got_data[$];

    // Scratch for table building
    logic [31:0] opnd_tmp;
    logic [3:0]  imm_sel [0:8] = '{4'd0, 4'd3, 4'd4, 4'd5, 4'd8, 4'd9, 4'd2, 4'd6, 4'd7};

    top u_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .iad     (iad),
        .idt     (idt),
        .acki_n  (acki_n),
        .dad     (dad),
        .ddt_in  (ddt_in),
        .ddt_out (ddt_out),
        .mreq    (mreq),
        .write   (write),
        .size    (size),
        .ackd_n  (ackd_n)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // RV32I integer results for the ten register ops
    function automatic logic [31:0] alu_ref(input logic [3:0] sel, input logic [31:0] a,
                                            input logic [31:0] b);
        case (sel)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a << b[4:0];
            4'd3:    return {31'b0, $signed(a) < $signed(b)};
            4'd4:    return {31'b0, a < b};
            4'd5:    return a ^ b;
            4'd6:    return a >> b[4:0];
            4'd7:    return $signed(a) >>> b[4:0];
            4'd8:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [3:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            4'd0:    return a == b;
            4'd1:    return a != b;
            4'd4:    return $signed(a) < $signed(b);
            4'd5:    return $signed(a) >= $signed(b);
            4'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(input logic [3:0] sel);
        case (sel)
            4'd0, 4'd1: return 3'd0;
            4'd2:       return 3'd1;
            4'd3:       return 3'd2;
            4'd4:       return 3'd3;
            4'd5:       return 3'd4;
            4'd6, 4'd7: return 3'd5;
            4'd8:       return 3'd6;
            default:    return 3'd7;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [3:0] sel, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        rv_pipe_pkg::instr_u w;
        w.r.funct7 = (sel == 4'd1 || sel == 4'd7) ? 7'h20 : 7'h00;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = funct3_of(sel);
        w.r.rd     = rd;
        w.r.opcode = rv_pipe_pkg::OP;
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        rv_pipe_pkg::instr_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [11:0] off);
        rv_pipe_pkg::instr_u w;
        w.s.imm_11_5 = off[11:5];
        w.s.rs2      = rs2;
        w.s.rs1      = 5'd0;
        w.s.funct3   = 3'd2;
        w.s.imm_4_0  = off[4:0];
        w.s.opcode   = rv_pipe_pkg::STORE;
        return w;
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] off);
        rv_pipe_pkg::instr_u w;
        w.b.imm_12   = off[12];
        w.b.imm_10_5 = off[10:5];
        w.b.rs2      = 5'd2;
        w.b.rs1      = 5'd1;
        w.b.funct3   = f3;
        w.b.imm_4_1  = off[4:1];
        w.b.imm_11   = off[11];
        w.b.opcode   = rv_pipe_pkg::BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[pc_idx] = w;
        pc_idx++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic add_row(input logic [3:0] kind, input logic [3:0] sel, input logic [31:0] a,
                           input logic [31:0] b, input logic stall, input string label);
        test_row_t r;
        r.kind  = kind;
        r.sel   = sel;
        r.a     = a;
        r.b     = b;
        r.stall = stall;
        rows.push_back(r);
        labels.push_back(label);
    endtask

    // Loads x1 with a and x2 with b in nine words
    // The operation lands at index 9
    task automatic emit_operands(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] ha;
        logic [31:0] hb;
        ha = a + 32'h800;
        hb = b + 32'h800;
        emit(enc_u(rv_pipe_pkg::LUI, 5'd1, ha[31:12]));
        emit(enc_u(rv_pipe_pkg::LUI, 5'd2, hb[31:12]));
        emit(NOP);
        emit(NOP);
        emit(enc_i(rv_pipe_pkg::OP_IMM, 3'd0, 5'd1, 5'd1, a[11:0]));
        emit(enc_i(rv_pipe_pkg::OP_IMM, 3'd0, 5'd2, 5'd2, b[11:0]));
        emit(NOP);
        emit(NOP);
        emit(NOP);
    endtask

    task automatic build_program(input test_row_t r);
        logic [31:0] opnd;
        logic [31:0] op_pc;
        logic        taken;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP;
        end
        exp_addr.delete();
        exp_data.delete();
        pc_idx = 0;
        emit_operands(r.a, r.b);
        op_pc = `RESET_PC + 32'd36;
        case (r.kind)
            K_RR, K_IMM, K_LUI, K_AUIPC: begin
                if (r.kind == K_RR) begin
                    emit(enc_r(r.sel, 5'd3, 5'd1, 5'd2));
                    expect_store(32'h100, alu_ref(r.sel, r.a, r.b));
                end else if (r.kind == K_IMM) begin
                    if (r.sel == 4'd2 || r.sel == 4'd6 || r.sel == 4'd7) begin
                        opnd = {27'b0, r.b[4:0]};
                        emit(enc_i(rv_pipe_pkg::OP_IMM, funct3_of(r.sel), 5'd3, 5'd1,
                                   {(r.sel == 4'd7) ? 7'h20 : 7'h00, r.b[4:0]}));
                    end else begin
                        opnd = {{20{r.b[11]}}, r.b[11:0]};
                        emit(enc_i(rv_pipe_pkg::OP_IMM, funct3_of(r.sel), 5'd3, 5'd1,
                                   r.b[11:0]));
                    end
                    expect_store(32'h100, alu_ref(r.sel, r.a, opnd));
                end else if (r.kind == K_LUI) begin
                    emit(enc_u(rv_pipe_pkg::LUI, 5'd3, r.b[19:0]));
                    expect_store(32'h100, {r.b[19:0], 12'h000});
                end else begin
                    emit(enc_u(rv_pipe_pkg::AUIPC, 5'd3, r.b[19:0]));
                    expect_store(32'h100, op_pc + {r.b[19:0], 12'h000});
                end
                emit(NOP);
                emit(NOP);
                emit(NOP);
                emit(enc_sw(5'd3, 12'h100));
            end
            K_LOAD: begin
                emit(enc_sw(5'd1, 12'h200));
                emit(enc_i(rv_pipe_pkg::LOAD, 3'd2, 5'd4, 5'd0, 12'h200));
                emit(NOP);
                emit(NOP);
                emit(NOP);
                emit(enc_sw(5'd4, 12'h204));
                expect_store(32'h200, r.a);
                expect_store(32'h204, r.a);
            end
            K_BR: begin
                // Branch at 9, delay slots 10 and 11, target 14
                taken = branch_ref(r.sel, r.a, r.b);
                emit(enc_b(r.sel[2:0], 13'd20));
                emit(enc_sw(5'd1, 12'h300));
                emit(enc_sw(5'd2, 12'h304));
                emit(enc_sw(5'd1, 12'h308));
                emit(enc_sw(5'd2, 12'h30c));
                emit(enc_sw(5'd1, 12'h310));
                expect_store(32'h300, r.a);
                expect_store(32'h304, r.b);
                if (!taken) begin
                    expect_store(32'h308, r.a);
                    expect_store(32'h30c, r.b);
                end
                expect_store(32'h310, r.a);
            end
            default: begin
                // Jump at 9 to 13, index 12 is skipped
                if (r.kind == K_JAL) begin
                    emit(enc_jal(5'd5, 21'd16));
                end else begin
                    emit(enc_i(rv_pipe_pkg::JALR, 3'd0, 5'd5, 5'd1, 12'd1));
                end
                emit(enc_sw(5'd1, 12'h400));
                emit(enc_sw(5'd2, 12'h404));
                emit(enc_sw(5'd2, 12'h410));
                emit(enc_sw(5'd1, 12'h408));
                emit(enc_sw(5'd5, 12'h40c));
                expect_store(32'h400, r.a);
                expect_store(32'h404, r.b);
                expect_store(32'h408, r.a);
                expect_store(32'h40c, op_pc + 32'd4);
            end
        endcase
    endtask

    // Memory models drive just after each rising edge
    always @(posedge clk) begin
        #0.5;
        rng = xorshift(rng);
        if (!rst_n) begin
            pending = 1'b0;
            acki_n  = 1'b0;
            ackd_n  = 1'b1;
        end else begin
            // Fetch stalls only while the data bus is idle
            acki_n = stall_mode && !mreq && rng[0];
            if (mreq) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = stall_mode ? int'(rng[9:8]) % 3 : 0;
                end
                if (wait_left == 0) begin
                    ackd_n  = 1'b0;
                    pending = 1'b0;
                    ddt_in  = dmem[dad[11:2]];
                end else begin
                    ackd_n = 1'b1;
                    wait_left--;
                end
            end else begin
                ackd_n = 1'b1;
            end
        end
        if (iad >= `RESET_PC && iad < `RESET_PC + IMEM_WORDS * 4) begin
            idt = imem[(iad - `RESET_PC) >> 2];
        end else begin
            idt = NOP;
        end
    end

    // Store capture, bus checks and run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the program did not finish", cycles);
            $display("Regression failed");
            $finish;
        end else if (rst_n) begin
            if (iad[1:0] !== 2'b00) begin
                $display("FAILED t=%0t iad[1:0] expected %h got %h", $time, 2'b00, iad[1:0]);
                bus_errs++;
            end
            if (mreq && !ackd_n) begin
                // Every access is a word
                if (size !== 2'b10) begin
                    $display("FAILED t=%0t size expected %h got %h", $time, 2'b10, size);
                    bus_errs++;
                end
                if (write) begin
                    got_addr.push_back(dad);
                    got_data.push_back(ddt_out);
                    dmem[dad[11:2]] = ddt_out;
                end
            end
        end
    end

    initial begin
        int fails;
        int passes;
        int errs;
        logic [3:0] br_f3 [0:5];
        clk        = 1'b0;
        rst_n      = 1'b0;
        idt        = NOP;
        acki_n     = 1'b1;
        ddt_in     = '0;
        ackd_n     = 1'b1;
        stall_mode = 1'b0;
        pending    = 1'b0;
        wait_left  = 0;
        cycles     = 0;
        bus_errs   = 0;
        limit      = 1000000;
        rng        = 32'h20aac6e3;
        fails      = 0;
        passes     = 0;
        br_f3      = '{4'd0, 4'd1, 4'd4, 4'd5, 4'd6, 4'd7};
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = {i[15:0], ~i[15:0]} ^ 32'h5a3c_96e1;
        end

        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 10; k++) begin
                rng = xorshift(rng);
                opnd_tmp = rng;
                rng = xorshift(rng);
                add_row(K_RR, 4'(k), opnd_tmp, rng, 1'(s), $sformatf("rr op %0d", k));
            end
            rng = xorshift(rng);
            add_row(K_LOAD, 4'd0, rng, 32'h0, 1'(s), "load path");
        end
        foreach (imm_sel[k]) begin
            rng = xorshift(rng);
            opnd_tmp = rng;
            rng = xorshift(rng);
            add_row(K_IMM, imm_sel[k], opnd_tmp, rng, 1'b0, $sformatf("imm op %0d", imm_sel[k]));
        end
        add_row(K_LUI, 4'd0, 32'h0, 32'h000a_bcde, 1'b0, "lui");
        add_row(K_AUIPC, 4'd0, 32'h0, 32'h0001_2345, 1'b0, "auipc");
        for (int k = 0; k < 6; k++) begin
            if (br_f3[k] < 4'd2) begin
                add_row(K_BR, br_f3[k], 32'd5, 32'd5, 1'b0, $sformatf("branch f3 %0d eq", k));
                add_row(K_BR, br_f3[k], 32'd5, 32'd6, 1'b0, $sformatf("branch f3 %0d ne", k));
            end else begin
                add_row(K_BR, br_f3[k], -32'sd3, 32'd2, 1'b0, $sformatf("branch idx %0d a", k));
                add_row(K_BR, br_f3[k], 32'd2, -32'sd3, 1'b0, $sformatf("branch idx %0d b", k));
            end
        end
        add_row(K_JAL, 4'd0, 32'h1234_5678, 32'h0bad_f00d, 1'b0, "jal");
        add_row(K_JALR, 4'd0, `RESET_PC + 32'd52, 32'h0bad_f00d, 1'b0, "jalr");
        limit = rows.size() * CYCLES_PER_TEST;

        foreach (rows[t]) begin
            errs = 0;
            build_program(rows[t]);
            @(posedge clk);
            #0.5;
            rst_n      = 1'b0;
            stall_mode = rows[t].stall;
            repeat (4) @(posedge clk);
            #0.5;
            got_addr.delete();
            got_data.delete();
            rst_n = 1'b1;
            while (got_addr.size() < exp_addr.size()) begin
                @(posedge clk);
            end
            // Extra cycles expose repeated or stray stores
            repeat (20) @(posedge clk);
            #0.5;
            foreach (exp_addr[i]) begin
                if (i >= got_addr.size()) begin
                    $display("Store %0d of test %s never appeared on the data bus", i, labels[t]);
                    errs++;
                end else begin
                    if (got_addr[i] !== exp_addr[i]) begin
                        $display("FAILED t=%0t dad expected %h got %h", $time, exp_addr[i],
                                 got_addr[i]);
                        errs++;
                    end
                    if (got_data[i] !== exp_data[i]) begin
                        $display("FAILED t=%0t ddt_out expected %h got %h", $time, exp_data[i],
                                 got_data[i]);
                        errs++;
                    end
                end
            end
            if (got_addr.size() > exp_addr.size()) begin
                $display("Test %s wrote %0d stores where %0d were due", labels[t],
                         got_addr.size(), exp_addr.size());
                errs++;
            end
            errs += bus_errs;
            bus_errs = 0;
            if (errs == 0) begin
                passes++;
                $display("test %0d %s%s: ok", t, labels[t], rows[t].stall ? " stalled" : "");
            end else begin
                fails++;
                $display("test %0d %s%s: %0d errors", t, labels[t],
                         rows[t].stall ? " stalled" : "", errs);
            end
        end

        $display("Tests run %0d, ok %0d, failing %0d", rows.size(), passes, fails);
        if (fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- rv_pipe.f
+incdir+include
source/rv_pipe_pkg.sv
source/id_stage.sv
source/rf32x32.sv
source/ex_stage.sv
source/mem_stage.sv
source/top.sv
tb/tb_top.sv

//--- run.sh
#!/bin/bash
# Build with Verilator and run; exit status follows the regression result
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f rv_pipe.f --top-module tb_top &&
out="$(./obj_dir/Vtb_top)" &&
echo "$out" &&
grep -q "Regression passed" <<< "$out" &&
exit 0 || exit 1
